/* logic/stream_cfg.svh */
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define STREAM_DATA_W      64     // one completion / stream beat
`define STREAM_ADDR_W      32     // host address and byte length
`define STREAM_BEAT_BYTES  8      // bytes carried by one beat

// ------------------------------
// request chunking
// ------------------------------
`define STREAM_CHUNK_BEATS 16     // beats per read request at most
`define STREAM_CHUNK_BYTES 128    // bytes per read request at most

// ------------------------------
// completion tags
// ------------------------------
`define STREAM_TAG_W       8
`define STREAM_TAG_A       8'd0   // tag of the first buffer
`define STREAM_TAG_B       8'd1   // tag of the second buffer

`endif

/* logic/stream_pkg.sv */
`include "stream_cfg.svh"

package stream_pkg;

  // ------------------------------
  // bus structures
  // ------------------------------
  typedef struct packed {
    logic [`STREAM_ADDR_W-1:0] src_addr;   // host buffer start
    logic [`STREAM_ADDR_W-1:0] len_bytes;  // transfer size in bytes
  } dma_cfg_t;

  typedef struct packed {
    logic [`STREAM_ADDR_W-1:0] addr;       // host address of this chunk
    logic [`STREAM_ADDR_W-1:0] len_bytes;  // chunk size in bytes
    logic [`STREAM_TAG_W-1:0]  tag;        // selects the landing buffer
  } rd_req_t;

  typedef struct packed {
    logic [`STREAM_TAG_W-1:0]  tag;
    logic [`STREAM_DATA_W-1:0] data;
  } cpl_t;

  // beat count that can hold a full chunk
  typedef logic [$clog2(`STREAM_CHUNK_BEATS):0] beat_cnt_t;

  // ------------------------------
  // enums
  // ------------------------------
  typedef enum logic {
    BUF_A = 1'b0,
    BUF_B = 1'b1
  } buf_sel_e;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,  // waiting for enable
    REQ_BUF   = 3'd1,  // waiting for the turn buffer to free up
    WAIT_ACK  = 3'd2,  // request held until acknowledged
    WAIT_DONE = 3'd3,  // all requested, counting beats in
    DRAIN     = 3'd4   // acknowledged, waiting for empty buffers
  } req_state_e;

endpackage

/* logic/tag_buffer.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module tag_buffer #(
  parameter int DEPTH = `STREAM_CHUNK_BEATS
) (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      wr_i,
  input  logic [`STREAM_DATA_W-1:0] wr_data_i,
  input  logic                      rd_i,
  output logic [`STREAM_DATA_W-1:0] rd_data_o,
  output logic                      empty_o,
  input  logic                      start_i,
  input  stream_pkg::beat_cnt_t     expect_i,
  output logic                      rcv_done_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [`STREAM_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [PTR_W:0]            count_q;
  stream_pkg::beat_cnt_t     rcv_cnt_q;
  stream_pkg::beat_cnt_t     expect_q;
  logic                      push;
  logic                      pop;

  // pointer wrap also covers depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // ------------------------------
  // storage
  // ------------------------------
  assign push      = wr_i && (count_q != (PTR_W + 1)'(DEPTH));
  assign pop       = rd_i && !empty_o;
  assign empty_o   = (count_q == '0);
  assign rd_data_o = mem[rd_ptr_q];  // head word shown ahead of the pop

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_q] <= wr_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // ------------------------------
  // received beats of the open request
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      rcv_cnt_q <= '0;
      expect_q  <= '0;
    end
    else if (start_i)
    begin
      rcv_cnt_q <= '0;        // new request on this tag
      expect_q  <= expect_i;
    end
    else if (wr_i)
      rcv_cnt_q <= rcv_cnt_q + 1'b1;
  end

  assign rcv_done_o = (rcv_cnt_q >= expect_q);

endmodule

/* logic/read_req_ctrl.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module read_req_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  stream_pkg::dma_cfg_t      cfg_i,
  input  logic                      en_i,
  input  logic                      done_ack_i,
  output logic                      done_o,
  output stream_pkg::rd_req_t       req_o,
  output logic                      req_valid_o,
  input  logic                      req_ack_i,
  input  logic [`STREAM_ADDR_W-1:0] rcvd_beats_i,
  input  logic [1:0]                buf_ready_i,
  output logic [1:0]                start_o,
  output stream_pkg::beat_cnt_t     expect_o,
  output logic                      clr_o,
  input  logic                      all_empty_i
);

  localparam int BEAT_SH = $clog2(`STREAM_BEAT_BYTES);
  localparam logic [`STREAM_ADDR_W-1:0] CHUNK_BYTES = `STREAM_CHUNK_BYTES;

  stream_pkg::req_state_e    state_q;
  stream_pkg::buf_sel_e      turn_q;
  stream_pkg::rd_req_t       req_q;
  logic                      req_valid_q;
  logic                      done_q;
  logic [`STREAM_ADDR_W-1:0] next_addr_q;
  logic [`STREAM_ADDR_W-1:0] rem_q;
  logic [`STREAM_ADDR_W-1:0] total_q;
  logic [`STREAM_ADDR_W-1:0] src_addr;
  logic [`STREAM_ADDR_W-1:0] src_rem;
  logic [`STREAM_ADDR_W-1:0] chunk_len;
  logic                      start_xfer;
  logic                      issue;

  // ------------------------------
  // next chunk
  // ------------------------------
  assign start_xfer = (state_q == stream_pkg::IDLE) && en_i;
  assign clr_o      = start_xfer;  // fresh counters for the new transfer

  always_comb
  begin
    if (state_q == stream_pkg::IDLE)
    begin
      src_addr = cfg_i.src_addr;                        // first chunk straight from cfg
      src_rem  = (cfg_i.len_bytes >> BEAT_SH) << BEAT_SH;  // partial beat dropped
    end
    else
    begin
      src_addr = next_addr_q;
      src_rem  = rem_q;
    end
    chunk_len = (src_rem > CHUNK_BYTES) ? CHUNK_BYTES : src_rem;
  end

  // a buffer is reused only once its last chunk is fully in and drained
  assign issue = (start_xfer || (state_q == stream_pkg::REQ_BUF))
              && (src_rem != '0) && buf_ready_i[turn_q];

  always_comb
  begin
    start_o         = '0;
    start_o[turn_q] = issue;
  end

  assign expect_o = stream_pkg::beat_cnt_t'(chunk_len >> BEAT_SH);

  // ------------------------------
  // request payload
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (start_xfer)
      total_q <= cfg_i.len_bytes >> BEAT_SH;  // beats expected overall
    if (issue)
    begin
      req_q.addr      <= src_addr;
      req_q.len_bytes <= chunk_len;
      req_q.tag       <= (turn_q == stream_pkg::BUF_A) ? `STREAM_TAG_A : `STREAM_TAG_B;
      next_addr_q     <= src_addr + CHUNK_BYTES;
      rem_q           <= src_rem - chunk_len;
    end
    else if (start_xfer)
    begin
      next_addr_q <= src_addr;  // buffer A busy so retry from REQ_BUF
      rem_q       <= src_rem;
    end
  end

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      state_q     <= stream_pkg::IDLE;
      turn_q      <= stream_pkg::BUF_A;
      req_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end
    else
    begin
      case (state_q)
        stream_pkg::IDLE:
        begin
          if (en_i)
          begin
            if (issue)
            begin
              req_valid_q <= 1'b1;
              state_q     <= stream_pkg::WAIT_ACK;
            end
            else if (src_rem == '0)
              state_q <= stream_pkg::WAIT_DONE;  // nothing to fetch
            else
              state_q <= stream_pkg::REQ_BUF;
          end
        end
        stream_pkg::REQ_BUF:
        begin
          if (issue)
          begin
            req_valid_q <= 1'b1;
            state_q     <= stream_pkg::WAIT_ACK;
          end
        end
        stream_pkg::WAIT_ACK:
        begin
          if (req_ack_i)
          begin
            req_valid_q <= 1'b0;
            if (rem_q == '0)
              state_q <= stream_pkg::WAIT_DONE;
            else
            begin
              turn_q  <= (turn_q == stream_pkg::BUF_A) ? stream_pkg::BUF_B : stream_pkg::BUF_A;
              state_q <= stream_pkg::REQ_BUF;
            end
          end
        end
        stream_pkg::WAIT_DONE:
        begin
          if (done_q && !en_i && done_ack_i)
          begin
            done_q  <= 1'b0;
            state_q <= stream_pkg::DRAIN;
          end
          else if (rcvd_beats_i >= total_q)
            done_q <= 1'b1;
        end
        stream_pkg::DRAIN:
        begin
          if (all_empty_i)
          begin
            turn_q  <= stream_pkg::BUF_A;  // next transfer starts on A
            state_q <= stream_pkg::IDLE;
          end
        end
        default:
          state_q <= stream_pkg::IDLE;
      endcase
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;
  assign done_o      = done_q;

endmodule

/* logic/stream_reorder.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module stream_reorder (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      clr_i,
  input  logic [`STREAM_DATA_W-1:0] data_a_i,
  input  logic [`STREAM_DATA_W-1:0] data_b_i,
  input  logic [1:0]                empty_i,
  input  logic                      ready_i,
  output logic [`STREAM_DATA_W-1:0] data_o,
  output logic                      valid_o,
  output logic [1:0]                rd_o
);

  localparam int CNT_W = $clog2(`STREAM_CHUNK_BEATS);
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`STREAM_CHUNK_BEATS - 1);

  stream_pkg::buf_sel_e cur_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 xfer;

  // ------------------------------
  // output mux
  // ------------------------------
  always_comb
  begin
    data_o     = (cur_q == stream_pkg::BUF_A) ? data_a_i : data_b_i;
    valid_o    = !empty_i[cur_q];
    rd_o       = '0;
    rd_o[cur_q] = ready_i && valid_o;  // pop only the buffer in turn
  end

  assign xfer = valid_o && ready_i;

  // ------------------------------
  // chunk walk
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n || clr_i)
    begin
      cur_q <= stream_pkg::BUF_A;
      cnt_q <= '0;
    end
    else if (xfer)
    begin
      if (cnt_q == LAST_BEAT)
      begin
        cnt_q <= '0;  // chunk done so hand over to the other buffer
        cur_q <= (cur_q == stream_pkg::BUF_A) ? stream_pkg::BUF_B : stream_pkg::BUF_A;
      end
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

/* logic/sys_user_stream.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module sys_user_stream (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  stream_pkg::dma_cfg_t      cfg_i,
  input  logic                      en_i,
  input  logic                      done_ack_i,
  output logic                      done_o,
  output stream_pkg::rd_req_t       req_o,
  output logic                      req_valid_o,
  input  logic                      req_ack_i,
  input  stream_pkg::cpl_t          cpl_i,
  input  logic                      cpl_valid_i,
  output logic [`STREAM_DATA_W-1:0] data_o,
  output logic                      valid_o,
  input  logic                      ready_i
);

  logic                      wr_a_q;
  logic                      wr_b_q;
  logic [`STREAM_DATA_W-1:0] cpl_data_q;
  logic [`STREAM_ADDR_W-1:0] rcvd_q;
  logic [`STREAM_DATA_W-1:0] data_a;
  logic [`STREAM_DATA_W-1:0] data_b;
  logic [1:0]                empty;
  logic [1:0]                rcv_done;
  logic [1:0]                start;
  logic [1:0]                rd;
  stream_pkg::beat_cnt_t     expect_cnt;
  logic                      clr;

  // ------------------------------
  // completion capture
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      wr_a_q <= 1'b0;
      wr_b_q <= 1'b0;
    end
    else
    begin
      wr_a_q <= cpl_valid_i && (cpl_i.tag == `STREAM_TAG_A);  // other tags fall through
      wr_b_q <= cpl_valid_i && (cpl_i.tag == `STREAM_TAG_B);
    end
  end

  always_ff @(posedge clk_i)
  begin
    cpl_data_q <= cpl_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n || clr)
      rcvd_q <= '0;
    else if (wr_a_q || wr_b_q)
      rcvd_q <= rcvd_q + 1'b1;  // beats in over the whole transfer
  end

  // ------------------------------
  // instances
  // ------------------------------
  read_req_ctrl i_ctrl (
    .clk_i, .rst_n, .cfg_i, .en_i, .done_ack_i, .done_o,
    .req_o, .req_valid_o, .req_ack_i,
    .rcvd_beats_i (rcvd_q),
    .buf_ready_i  (rcv_done & empty),
    .start_o      (start),
    .expect_o     (expect_cnt),
    .clr_o        (clr),
    .all_empty_i  (&empty)
  );

  tag_buffer i_buf_a (
    .clk_i, .rst_n,
    .wr_i (wr_a_q), .wr_data_i (cpl_data_q),
    .rd_i (rd[stream_pkg::BUF_A]), .rd_data_o (data_a), .empty_o (empty[stream_pkg::BUF_A]),
    .start_i (start[stream_pkg::BUF_A]), .expect_i (expect_cnt),
    .rcv_done_o (rcv_done[stream_pkg::BUF_A])
  );

  tag_buffer i_buf_b (
    .clk_i, .rst_n,
    .wr_i (wr_b_q), .wr_data_i (cpl_data_q),
    .rd_i (rd[stream_pkg::BUF_B]), .rd_data_o (data_b), .empty_o (empty[stream_pkg::BUF_B]),
    .start_i (start[stream_pkg::BUF_B]), .expect_i (expect_cnt),
    .rcv_done_o (rcv_done[stream_pkg::BUF_B])
  );

  stream_reorder i_reorder (
    .clk_i, .rst_n,
    .clr_i (clr), .data_a_i (data_a), .data_b_i (data_b), .empty_i (empty),
    .ready_i, .data_o, .valid_o, .rd_o (rd)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #10 clk_o = ~clk_o;  // 20 ns period
  end

  // reset spans the first two rising edges
  initial
  begin
    rst_n_o = 1'b0;
    repeat (2)
      @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* tests/tb_sys_user_stream.sv */
`timescale 1ns/100ps
`include "stream_cfg.svh"

module tb_sys_user_stream;

  localparam int TIMEOUT = 4000;  // cycles allowed for any one wait

  logic                      clk;
  logic                      rst_n;
  stream_pkg::dma_cfg_t      cfg;
  logic                      en;
  logic                      done_ack;
  logic                      done;
  stream_pkg::rd_req_t       req;
  logic                      req_valid;
  logic                      req_ack;
  stream_pkg::cpl_t          cpl;
  logic                      cpl_valid;
  logic [`STREAM_DATA_W-1:0] data;
  logic                      valid;
  logic                      ready;

  integer                    seed = 32'ha81e;
  logic [`STREAM_ADDR_W-1:0] base_addr = '0;
  logic [`STREAM_ADDR_W-1:0] xfer_len = '0;
  int                        exp_beats = 0;
  int                        exp_reqs = 0;
  int                        req_idx = 0;     // requests accepted by the host
  int                        beat_idx = 0;    // beats taken from the output stream
  int                        sent_beats = 0;  // completion beats issued
  int                        ack_delay = -1;
  logic [`STREAM_DATA_W-1:0] q_a[$];
  logic [`STREAM_DATA_W-1:0] q_b[$];

  tb_clock i_clk (.clk_o (clk), .rst_n_o (rst_n));

  sys_user_stream i_dut (
    .clk_i (clk), .rst_n (rst_n), .cfg_i (cfg), .en_i (en), .done_ack_i (done_ack),
    .done_o (done), .req_o (req), .req_valid_o (req_valid), .req_ack_i (req_ack),
    .cpl_i (cpl), .cpl_valid_i (cpl_valid), .data_o (data), .valid_o (valid),
    .ready_i (ready)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [`STREAM_DATA_W-1:0] beat_value(input logic [`STREAM_ADDR_W-1:0] a);
    logic [`STREAM_DATA_W-1:0] w;
    w = {32'b0, a};
    return w ^ (w << 32);
  endfunction

  // request n of the current transfer
  function automatic stream_pkg::rd_req_t ref_req(input int n);
    stream_pkg::rd_req_t       r;
    logic [`STREAM_ADDR_W-1:0] left;
    left        = (xfer_len & ~32'h7) - 32'(n) * `STREAM_CHUNK_BYTES;
    r.addr      = base_addr + 32'(n) * `STREAM_CHUNK_BYTES;
    r.len_bytes = (left > `STREAM_CHUNK_BYTES) ? `STREAM_CHUNK_BYTES : left;
    r.tag       = n[0] ? `STREAM_TAG_B : `STREAM_TAG_A;  // A, B, A, B ...
    return r;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic string ctrl_state();
    stream_pkg::req_state_e s;
    s = i_dut.i_ctrl.state_q;
    return s.name();
  endfunction

  // ------------------------------
  // checks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_req(input string name, input stream_pkg::rd_req_t got,
                           input stream_pkg::rd_req_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [`STREAM_DATA_W-1:0] got,
                            input logic [`STREAM_DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic step_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // ------------------------------
  // host model
  // ------------------------------
  task automatic accept_req();
    int k;
    if (req_idx >= exp_reqs)
      abort_run("the DUT issued a read request beyond the end of the transfer");
    else
    begin
      check_req("req_o", req, ref_req(req_idx));
      for (k = 0; k < int'(req.len_bytes >> 3); k++)
      begin
        if (req.tag == `STREAM_TAG_A)
          q_a.push_back(beat_value(req.addr + 32'(k * `STREAM_BEAT_BYTES)));
        else
          q_b.push_back(beat_value(req.addr + 32'(k * `STREAM_BEAT_BYTES)));
      end
      req_idx = req_idx + 1;
    end
  endtask

  always
  begin
    @(posedge clk);
    #1;
    cpl_valid = 1'b0;
    if ((q_a.size() + q_b.size() != 0) && (rand_below(3) != 0))
    begin
      if (q_b.size() == 0 || (q_a.size() != 0 && rand_below(2) == 0))
      begin
        cpl.tag  = `STREAM_TAG_A;
        cpl.data = q_a.pop_front();
      end
      else
      begin
        cpl.tag  = `STREAM_TAG_B;
        cpl.data = q_b.pop_front();  // tags interleave out of order
      end
      cpl_valid  = 1'b1;
      sent_beats = sent_beats + 1;
    end
    if (req_ack)
      req_ack = 1'b0;  // taken at this edge
    else if (req_valid)
    begin
      if (ack_delay < 0)
        ack_delay = rand_below(4);
      if (ack_delay == 0)
      begin
        accept_req();
        req_ack   = 1'b1;
        ack_delay = -1;
      end
      else
        ack_delay = ack_delay - 1;
    end
    ready = (rand_below(4) != 0);  // low about a quarter of the time
  end

  // ------------------------------
  // output stream compare
  // ------------------------------
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (done && (sent_beats != exp_beats))
        abort_run("done_o is high before all completion beats were sent");
      else if (valid && ready && (beat_idx >= exp_beats))
        abort_run("the DUT sent an output beat beyond the end of the transfer");
      else if (valid && ready)
      begin
        check_data("data_o", data, beat_value(base_addr + 32'(beat_idx * `STREAM_BEAT_BYTES)));
        beat_idx = beat_idx + 1;
      end
    end
  end

  task automatic run_transfer(input logic [`STREAM_ADDR_W-1:0] addr,
                              input logic [`STREAM_ADDR_W-1:0] len);
    int cnt;
    base_addr     = addr;
    xfer_len      = len;
    exp_beats     = int'(len >> 3);
    exp_reqs      = (exp_beats + `STREAM_CHUNK_BEATS - 1) / `STREAM_CHUNK_BEATS;
    req_idx       = 0;
    beat_idx      = 0;
    sent_beats    = 0;
    cfg.src_addr  = addr;
    cfg.len_bytes = len;
    en            = 1'b1;
    cnt = 0;
    while (!done && cnt < TIMEOUT)
    begin
      step_cycles(1);
      cnt = cnt + 1;
    end
    if (!done)
      abort_run($sformatf("timeout waiting for done_o, controller in %s", ctrl_state()));
    // done must survive an acknowledge under enable and then a lone enable drop
    done_ack = 1'b1;
    step_cycles(2);
    check_flag("done_o", done, 1'b1);
    done_ack = 1'b0;
    en       = 1'b0;
    step_cycles(2);
    check_flag("done_o", done, 1'b1);
    done_ack = 1'b1;
    step_cycles(1);
    check_flag("done_o", done, 1'b0);
    done_ack = 1'b0;
    cnt = 0;
    while (beat_idx < exp_beats && cnt < TIMEOUT)
    begin
      step_cycles(1);
      cnt = cnt + 1;
    end
    if (beat_idx < exp_beats)
      abort_run($sformatf("timeout on the output stream after %0d of %0d beats",
                          beat_idx, exp_beats));
    cnt = 0;
    while (i_dut.i_ctrl.state_q != stream_pkg::IDLE && cnt < TIMEOUT)
    begin
      step_cycles(1);
      cnt = cnt + 1;
    end
    if (i_dut.i_ctrl.state_q != stream_pkg::IDLE)
      abort_run($sformatf("controller stuck in %s after the transfer", ctrl_state()));
    if (req_idx != exp_reqs)
      abort_run($sformatf("the DUT issued %0d read requests where %0d were due",
                          req_idx, exp_reqs));
  endtask

  // ------------------------------
  // sequence
  // ------------------------------
  initial
  begin
    int cnt;
    cfg       = '0;
    en        = 1'b0;
    done_ack  = 1'b0;
    req_ack   = 1'b0;
    cpl       = '0;
    cpl_valid = 1'b0;
    ready     = 1'b0;
    cnt = 0;
    do
    begin
      @(negedge clk);
      cnt = cnt + 1;
    end
    while (!rst_n && cnt < TIMEOUT);
    if (!rst_n)
      abort_run("reset was never released");
    check_flag("req_valid_o", req_valid, 1'b0);
    check_flag("valid_o", valid, 1'b0);
    check_flag("done_o", done, 1'b0);
    step_cycles(1);
    run_transfer(32'h0000_1000, 32'd1000);
    run_transfer(32'h0000_3000, 32'd0);     // no request and no beat
    run_transfer(32'h0002_4000, 32'd1000);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/stream_pkg.sv
logic/tag_buffer.sv
logic/read_req_ctrl.sv
logic/stream_reorder.sv
logic/sys_user_stream.sv
tests/tb_clock.sv
tests/tb_sys_user_stream.sv

/* run.sh */
#!/bin/sh
# build and run the sys_user_stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_sys_user_stream

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f src.f -Mdir obj_dir -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation finished without failure"
exit 0
